/* hw/axi_bus_pkg.sv */
`default_nettype none

package axi_bus_pkg;

  ////////////////////
  // channel field widths
  ////////////////////

  // byte address on both address channels
  typedef logic [48:0]  axi_addr_t;
  // one 128-bit data beat
  typedef logic [127:0] axi_data_t;
  // one strobe bit per data byte
  typedef logic [15:0]  axi_strb_t;
  // beats in burst minus one
  typedef logic [7:0]   axi_len_t;
  // log2 of bytes per beat
  typedef logic [2:0]   axi_size_t;
  // FIXED / INCR / WRAP
  typedef logic [1:0]   axi_burst_t;

  // incrementing burst
  localparam axi_burst_t AXI_BURST_INCR = 2'd1;
  // 16 bytes per beat, full bus width
  localparam axi_size_t  AXI_SIZE_16B   = 3'd4;
  // byte count of one beat, used for the frame stride
  localparam int unsigned AXI_BEAT_BYTES = 16;

endpackage

`default_nettype wire

/* hw/frame_pkg.sv */
`default_nettype none

package frame_pkg;

  // free running cycle counters
  typedef logic [63:0] cycle_t;
  // frame slot within one round
  typedef logic [7:0]  frame_idx_t;
  // beat position inside a burst
  typedef logic [7:0]  beat_idx_t;
  // low half of the doorbell word
  typedef logic [63:0] poll_word_t;

  // last-seen doorbell value after reset
  localparam poll_word_t DOORBELL_INIT = 64'hdeadbeff;

  ////////////////////
  // sequencer states
  ////////////////////

  // burst writer
  typedef enum logic [2:0] {
    W_IDLE, W_ADDR, W_DATA, W_BEAT_WAIT, W_RESP, W_HOLD
  } write_state_t;

  // doorbell reader, only active in W_HOLD
  typedef enum logic [1:0] {
    P_IDLE, P_ADDR, P_RREADY, P_DATA
  } poll_state_t;

endpackage

`default_nettype wire

/* hw/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  input  logic en,
  input  logic frame_valid,
  input  logic frames_left,
  input  logic beat_last,
  input  logic word_changed,
  input  logic s_axi_awready,
  input  logic s_axi_wready,
  input  logic s_axi_bvalid,
  input  logic s_axi_arready,
  input  logic s_axi_rvalid,
  output logic load_frame,
  output logic shift_beat,
  output logic next_frame,
  output logic wrap_frames,
  output logic sample_word,
  output logic s_axi_awvalid,
  output logic s_axi_wvalid,
  output logic s_axi_wlast,
  output logic s_axi_bready,
  output logic s_axi_arvalid,
  output logic s_axi_rready,
  output logic frame_ack
);

  import frame_pkg::*;

  write_state_t w_state;
  poll_state_t  p_state;

  logic start_frame;
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  // channel handshakes
  assign aw_hs = s_axi_awvalid && s_axi_awready;
  assign w_hs  = s_axi_wvalid && s_axi_wready;
  assign b_hs  = s_axi_bvalid && s_axi_bready;
  assign ar_hs = s_axi_arvalid && s_axi_arready;
  assign r_hs  = s_axi_rvalid && s_axi_rready;

  // new frame accepted while slots remain
  assign start_frame = (w_state == W_IDLE) && frame_valid && frames_left;

  // strobes to the datapaths
  assign load_frame  = start_frame;
  // address is registered on the same edge awvalid rises
  assign next_frame  = start_frame;
  assign shift_beat  = w_hs;
  // rready is only high in P_DATA
  assign sample_word = r_hs;
  assign wrap_frames = (w_state == W_HOLD) && r_hs && word_changed;

  ////////////////////
  // write machine
  ////////////////////

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      w_state       <= W_IDLE;
      s_axi_awvalid <= 1'b0;
      s_axi_wvalid  <= 1'b0;
      s_axi_wlast   <= 1'b0;
      s_axi_bready  <= 1'b0;
      frame_ack     <= 1'b0;
    end else begin
      // ack is a single cycle pulse
      frame_ack <= 1'b0;
      case (w_state)
        W_IDLE: begin
          if (start_frame) begin
            s_axi_awvalid <= 1'b1;
            w_state       <= W_ADDR;
          end
        end
        W_ADDR: begin
          if (aw_hs) begin
            s_axi_awvalid <= 1'b0;
            w_state       <= W_DATA;
          end
        end
        W_DATA: begin
          // present next beat, bready goes up with the last one
          s_axi_wvalid <= 1'b1;
          s_axi_wlast  <= beat_last;
          s_axi_bready <= beat_last;
          w_state      <= W_BEAT_WAIT;
        end
        W_BEAT_WAIT: begin
          if (w_hs) begin
            s_axi_wvalid <= 1'b0;
            s_axi_wlast  <= 1'b0;
            w_state      <= s_axi_wlast ? W_RESP : W_DATA;
          end
        end
        W_RESP: begin
          if (b_hs) begin
            s_axi_bready <= 1'b0;
            if (frames_left) begin
              frame_ack <= 1'b1;
              w_state   <= W_IDLE;
            end else begin
              w_state <= W_HOLD;
            end
          end
        end
        W_HOLD: begin
          // doorbell moved, start the next round
          if (wrap_frames) begin
            frame_ack <= 1'b1;
            w_state   <= W_IDLE;
          end
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  ////////////////////
  // poll machine
  ////////////////////

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      p_state       <= P_IDLE;
      s_axi_arvalid <= 1'b0;
      s_axi_rready  <= 1'b0;
    end else begin
      case (p_state)
        P_IDLE: begin
          // only poll once the round is used up
          if (w_state == W_HOLD) begin
            s_axi_arvalid <= 1'b1;
            p_state       <= P_ADDR;
          end
        end
        P_ADDR: begin
          if (ar_hs) begin
            s_axi_arvalid <= 1'b0;
            p_state       <= P_RREADY;
          end
        end
        P_RREADY: begin
          s_axi_rready <= 1'b1;
          p_state      <= P_DATA;
        end
        P_DATA: begin
          // unchanged word re-reads from idle
          if (r_hs) begin
            s_axi_rready <= 1'b0;
            p_state      <= P_IDLE;
          end
        end
        default: p_state <= P_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/frame_beat_path.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_beat_path #(
  parameter int unsigned BEATS_PER_FRAME = 13
) (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  input  logic                      en,
  input  logic [BEATS_PER_FRAME*$bits(axi_bus_pkg::axi_data_t)-1:0] frame_data,
  input  logic                      load_frame,
  input  logic                      shift_beat,
  output axi_bus_pkg::axi_data_t    s_axi_wdata,
  output logic                      beat_last
);

  import axi_bus_pkg::*;
  import frame_pkg::*;

  localparam int unsigned FRAME_BITS = BEATS_PER_FRAME * $bits(axi_data_t);

  // remaining beats, lowest slice goes out first
  logic [FRAME_BITS-1:0] frame_reg;
  beat_idx_t             beat_cnt;

  ////////////////////
  // frame shifter
  ////////////////////

  always_ff @(posedge s_axi_aclk) begin
    if (load_frame) begin
      frame_reg <= frame_data;
    end else if (shift_beat) begin
      frame_reg <= frame_reg >> $bits(axi_data_t);
    end
  end

  // beat position, restarts with every frame
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      beat_cnt <= '0;
    end else if (load_frame) begin
      beat_cnt <= '0;
    end else if (shift_beat) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign s_axi_wdata = frame_reg[$bits(axi_data_t)-1:0];
  // presented beat is the final one of the burst
  assign beat_last   = (beat_cnt == beat_idx_t'(BEATS_PER_FRAME - 1));

endmodule

`default_nettype wire

/* hw/frame_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_addr_gen #(
  parameter int unsigned           FRAME_COUNT     = 19,
  parameter int unsigned           BEATS_PER_FRAME = 13,
  parameter axi_bus_pkg::axi_addr_t BASE_ADDR      = '0
) (
  input  logic                   s_axi_aclk,
  input  logic                   s_axi_aresetn,
  input  logic                   en,
  input  logic                   next_frame,
  input  logic                   wrap_frames,
  output axi_bus_pkg::axi_addr_t s_axi_awaddr,
  output logic                   frames_left
);

  import axi_bus_pkg::*;
  import frame_pkg::*;

  // one frame in bytes, 208 for 13 beats
  localparam axi_addr_t STRIDE = axi_addr_t'(BEATS_PER_FRAME * AXI_BEAT_BYTES);

  frame_idx_t frame_idx;

  // address latched from the old index as it advances
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      frame_idx    <= '0;
      s_axi_awaddr <= '0;
    end else if (wrap_frames) begin
      frame_idx <= '0;
    end else if (next_frame) begin
      s_axi_awaddr <= BASE_ADDR + axi_addr_t'(frame_idx) * STRIDE;
      frame_idx    <= frame_idx + 1'b1;
    end
  end

  assign frames_left = (frame_idx < frame_idx_t'(FRAME_COUNT));

endmodule

`default_nettype wire

/* hw/doorbell_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module doorbell_tracker (
  input  logic                   s_axi_aclk,
  input  logic                   s_axi_aresetn,
  input  logic                   en,
  input  axi_bus_pkg::axi_data_t s_axi_rdata,
  input  logic                   sample_word,
  output logic                   word_changed
);

  import frame_pkg::*;

  // low half of the last doorbell value seen
  poll_word_t last_word;

  // compare straight off the read bus
  assign word_changed = (s_axi_rdata[$bits(poll_word_t)-1:0] != last_word);

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      last_word <= DOORBELL_INIT;
    end else if (sample_word && word_changed) begin
      last_word <= s_axi_rdata[$bits(poll_word_t)-1:0];
    end
  end

endmodule

`default_nettype wire

/* hw/cycle_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_counters (
  input  logic              s_axi_aclk,
  input  logic              s_axi_aresetn,
  input  logic              en,
  input  frame_pkg::cycle_t break_count,
  input  logic              s_axi_awvalid,
  input  logic              s_axi_awready,
  output frame_pkg::cycle_t all_cycle,
  output frame_pkg::cycle_t cpu_cycle
);

  // measurement window closes at break_count
  logic do_counting;

  assign do_counting = (all_cycle < break_count);

  // enabled cycles, en low restarts the window
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      all_cycle <= '0;
    end else if (do_counting) begin
      all_cycle <= all_cycle + 1'b1;
    end
  end

  // AW handshakes inside the window, survives en low
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      cpu_cycle <= '0;
    end else if (en && do_counting && s_axi_awvalid && s_axi_awready) begin
      cpu_cycle <= cpu_cycle + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/frame_writer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_writer_top #(
  parameter int unsigned            FRAME_COUNT     = 19,
  parameter int unsigned            BEATS_PER_FRAME = 13,
  parameter axi_bus_pkg::axi_addr_t BASE_ADDR       = '0,
  parameter axi_bus_pkg::axi_addr_t POLL_ADDR       = 'hF70
) (
  input  logic                       s_axi_aclk,
  input  logic                       s_axi_aresetn,
  input  logic                       en,
  input  logic [BEATS_PER_FRAME*$bits(axi_bus_pkg::axi_data_t)-1:0] frame_data,
  input  logic                       frame_valid,
  output logic                       frame_ack,
  input  frame_pkg::cycle_t          break_count,
  output frame_pkg::cycle_t          all_cycle,
  output frame_pkg::cycle_t          cpu_cycle,
  output axi_bus_pkg::axi_addr_t     s_axi_awaddr,
  output axi_bus_pkg::axi_len_t      s_axi_awlen,
  output axi_bus_pkg::axi_size_t     s_axi_awsize,
  output axi_bus_pkg::axi_burst_t    s_axi_awburst,
  output logic                       s_axi_awvalid,
  input  logic                       s_axi_awready,
  output axi_bus_pkg::axi_data_t     s_axi_wdata,
  output axi_bus_pkg::axi_strb_t     s_axi_wstrb,
  output logic                       s_axi_wlast,
  output logic                       s_axi_wvalid,
  input  logic                       s_axi_wready,
  input  logic [1:0]                 s_axi_bresp,
  input  logic                       s_axi_bvalid,
  output logic                       s_axi_bready,
  output axi_bus_pkg::axi_addr_t     s_axi_araddr,
  output axi_bus_pkg::axi_len_t      s_axi_arlen,
  output axi_bus_pkg::axi_size_t     s_axi_arsize,
  output axi_bus_pkg::axi_burst_t    s_axi_arburst,
  output logic                       s_axi_arvalid,
  input  logic                       s_axi_arready,
  input  axi_bus_pkg::axi_data_t     s_axi_rdata,
  input  logic [1:0]                 s_axi_rresp,
  input  logic                       s_axi_rlast,
  input  logic                       s_axi_rvalid,
  output logic                       s_axi_rready
);

  import axi_bus_pkg::*;

  logic load_frame;
  logic shift_beat;
  logic next_frame;
  logic wrap_frames;
  logic sample_word;
  logic beat_last;
  logic frames_left;
  logic word_changed;

  ////////////////////
  // fixed channel fields
  ////////////////////

  // one burst per frame, full width beats
  assign s_axi_awlen   = axi_len_t'(BEATS_PER_FRAME - 1);
  assign s_axi_awsize  = AXI_SIZE_16B;
  assign s_axi_awburst = AXI_BURST_INCR;
  assign s_axi_wstrb   = '1;
  // doorbell is a single beat read
  assign s_axi_araddr  = POLL_ADDR;
  assign s_axi_arlen   = '0;
  assign s_axi_arsize  = AXI_SIZE_16B;
  assign s_axi_arburst = AXI_BURST_INCR;
  // bresp, rresp and rlast are not checked, a single read beat is always last

  frame_sequencer u_seq (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .en            (en),
    .frame_valid   (frame_valid),
    .frames_left   (frames_left),
    .beat_last     (beat_last),
    .word_changed  (word_changed),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid  (s_axi_rvalid),
    .load_frame    (load_frame),
    .shift_beat    (shift_beat),
    .next_frame    (next_frame),
    .wrap_frames   (wrap_frames),
    .sample_word   (sample_word),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wlast   (s_axi_wlast),
    .s_axi_bready  (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_rready  (s_axi_rready),
    .frame_ack     (frame_ack)
  );

  frame_beat_path #(
    .BEATS_PER_FRAME (BEATS_PER_FRAME)
  ) u_beat (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .en            (en),
    .frame_data    (frame_data),
    .load_frame    (load_frame),
    .shift_beat    (shift_beat),
    .s_axi_wdata   (s_axi_wdata),
    .beat_last     (beat_last)
  );

  frame_addr_gen #(
    .FRAME_COUNT     (FRAME_COUNT),
    .BEATS_PER_FRAME (BEATS_PER_FRAME),
    .BASE_ADDR       (BASE_ADDR)
  ) u_addr (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .en            (en),
    .next_frame    (next_frame),
    .wrap_frames   (wrap_frames),
    .s_axi_awaddr  (s_axi_awaddr),
    .frames_left   (frames_left)
  );

  doorbell_tracker u_bell (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .en            (en),
    .s_axi_rdata   (s_axi_rdata),
    .sample_word   (sample_word),
    .word_changed  (word_changed)
  );

  cycle_counters u_cnt (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .en            (en),
    .break_count   (break_count),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .all_cycle     (all_cycle),
    .cpu_cycle     (cpu_cycle)
  );

endmodule

`default_nettype wire

/* test/frame_writer_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_writer_sva (
  input logic                   s_axi_aclk,
  input logic                   s_axi_aresetn,
  input logic                   en,
  input axi_bus_pkg::axi_addr_t s_axi_awaddr,
  input logic                   s_axi_awvalid,
  input logic                   s_axi_awready,
  input axi_bus_pkg::axi_data_t s_axi_wdata,
  input logic                   s_axi_wvalid,
  input logic                   s_axi_wready,
  input logic                   s_axi_wlast,
  input logic                   s_axi_bvalid,
  input logic                   s_axi_bready,
  input logic                   s_axi_arvalid,
  input logic                   s_axi_arready
);

  // high from AW handshake until the write response
  logic burst_open;

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !en) begin
      burst_open <= 1'b0;
    end else if (s_axi_awvalid && s_axi_awready) begin
      burst_open <= 1'b1;
    end else if (s_axi_bvalid && s_axi_bready) begin
      burst_open <= 1'b0;
    end
  end

  ////////////////////
  // channel rules
  ////////////////////

  // payload holds under back-pressure
  aw_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn || !en)
    s_axi_awvalid && !s_axi_awready |=> s_axi_awvalid && $stable(s_axi_awaddr))
    else $error("awvalid or awaddr changed before handshake");
  w_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn || !en)
    s_axi_wvalid && !s_axi_wready |=> s_axi_wvalid && $stable(s_axi_wdata)
      && $stable(s_axi_wlast))
    else $error("wvalid or beat changed before handshake");
  ar_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn || !en)
    s_axi_arvalid && !s_axi_arready |=> s_axi_arvalid)
    else $error("arvalid dropped before handshake");
  // one burst in flight at most
  no_aw_open: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn || !en)
    burst_open |-> !s_axi_awvalid)
    else $error("awvalid while a burst is open");
  wlast_valid: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn || !en)
    s_axi_wlast |-> s_axi_wvalid)
    else $error("wlast without wvalid");

endmodule

bind frame_writer_top frame_writer_sva u_sva (
  .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn), .en(en),
  .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
  .s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
  .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
  .s_axi_wlast(s_axi_wlast), .s_axi_bvalid(s_axi_bvalid),
  .s_axi_bready(s_axi_bready), .s_axi_arvalid(s_axi_arvalid),
  .s_axi_arready(s_axi_arready)
);

`default_nettype wire

/* test/tb_frame_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frame_writer;

  localparam int FRAMES = 3;
  localparam int BEATS = 4;
  // rough length of all tests in clock cycles
  localparam int TEST_CYCLES = 420;

  logic s_axi_aclk = 1'b0;
  logic s_axi_aresetn, en, frame_valid, frame_ack;
  logic [BEATS*128-1:0] frame_data;
  logic [63:0] break_count, all_cycle, cpu_cycle;
  logic [48:0] s_axi_awaddr, s_axi_araddr;
  logic [7:0] s_axi_awlen, s_axi_arlen;
  logic [2:0] s_axi_awsize, s_axi_arsize;
  logic [1:0] s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
  logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic s_axi_rlast, s_axi_rvalid, s_axi_rready;
  logic [127:0] s_axi_wdata, s_axi_rdata;
  logic [15:0] s_axi_wstrb;

  integer seed = 71798;
  string test_name = "reset";
  logic [BEATS*128-1:0] frames [0:7];
  logic [63:0] script [0:1];
  logic [63:0] last_seen = 64'hdeadbeff;
  int errors = 0, test_errors = 0, passed = 0, failed = 0;
  int aw_count = 0, beat_num = 0, burst_frame = 0, bursts_done = 0, cur_frame = 0;
  int acks = 0, acks_expected = 0, exp_cpu = 0, word_idx = 0;
  int hold_reads = 0, release_reads = 0, releases = 0, n;
  logic b_pending = 1'b0, r_pending = 1'b0, in_hold = 1'b0;

  frame_writer_top #(.FRAME_COUNT(FRAMES), .BEATS_PER_FRAME(BEATS)) DUT (.*);

  always #2 s_axi_aclk = ~s_axi_aclk;

  task automatic check_val(input string what, input logic [127:0] expv,
                           input logic [127:0] actv);
    assert (expv === actv) else begin
      $display("Error: %s %s expected %0h actual %0h", test_name, what, expv, actv);
      errors++;
    end
  endtask

  task automatic fail_wait(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    errors++;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      $display("test %s: passed", test_name);
      passed++;
    end else begin
      $display("test %s: failed with %0d errors", test_name, errors - test_errors);
      failed++;
    end
    test_errors = errors;
  endtask

  ////////////////////
  // bus monitor
  ////////////////////

  always @(posedge s_axi_aclk) begin
    if (s_axi_aresetn && en) begin
      // cpu_cycle window closes once all_cycle reaches break_count
      if (s_axi_awvalid && s_axi_awready && all_cycle < break_count) exp_cpu++;
      if (in_hold) check_val("awvalid in poll", 128'(0), 128'(s_axi_awvalid));
      if (s_axi_awvalid && s_axi_awready) begin
        check_val("awaddr", 128'((aw_count % FRAMES) * 64), 128'(s_axi_awaddr));
        check_val("awlen", 128'(3), 128'(s_axi_awlen));
        check_val("awsize", 128'(4), 128'(s_axi_awsize));
        check_val("awburst", 128'(1), 128'(s_axi_awburst));
        aw_count++;
        beat_num = 0;
        burst_frame = cur_frame;
      end
      if (s_axi_wvalid && s_axi_wready) begin
        check_val("wdata", frames[burst_frame % 8][beat_num*128 +: 128], s_axi_wdata);
        check_val("wlast", 128'(beat_num == BEATS - 1), 128'(s_axi_wlast));
        check_val("wstrb", 128'(16'hffff), 128'(s_axi_wstrb));
        if (s_axi_wlast) b_pending = 1'b1;
        beat_num++;
      end
      if (s_axi_bvalid && s_axi_bready) begin
        b_pending = 1'b0;
        bursts_done++;
        // third burst of a round ends in the poll loop
        if (bursts_done % FRAMES != 0) begin
          acks_expected++;
        end else begin
          in_hold = 1'b1;
          hold_reads = 0;
        end
      end
      if (s_axi_arvalid && s_axi_arready) begin
        check_val("araddr", 128'(12'hf70), 128'(s_axi_araddr));
        check_val("arlen", 128'(0), 128'(s_axi_arlen));
        check_val("arsize", 128'(4), 128'(s_axi_arsize));
        check_val("arburst", 128'(1), 128'(s_axi_arburst));
        r_pending = 1'b1;
      end
      if (s_axi_rvalid && s_axi_rready) begin
        r_pending = 1'b0;
        hold_reads++;
        if (word_idx < 1) word_idx++;
        // a new doorbell value releases the hold
        if (s_axi_rdata[63:0] != last_seen) begin
          last_seen = s_axi_rdata[63:0];
          acks_expected++;
          in_hold = 1'b0;
          release_reads = hold_reads;
          releases++;
        end
      end
    end
  end

  ////////////////////
  // slave and producer
  ////////////////////

  always @(negedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      s_axi_awready = 1'b0;
      s_axi_wready = 1'b0;
      s_axi_arready = 1'b0;
    end else begin
      // random stalls on every ready
      s_axi_awready = ($random(seed) % 2 == 0);
      s_axi_wready = ($random(seed) % 2 == 0);
      s_axi_arready = ($random(seed) % 2 == 0);
    end
    s_axi_bvalid = b_pending;
    s_axi_rvalid = r_pending;
    // upper half carries no doorbell bits
    s_axi_rdata = {64'h5a5a_a5a5_5a5a_a5a5, script[word_idx]};
    if (frame_ack) begin
      acks++;
      assert (acks <= acks_expected) else begin
        $display("%s: frame_ack pulsed without a finished burst or doorbell change",
                 test_name);
        errors++;
      end
      // next frame goes up right away
      cur_frame++;
      frame_data = frames[cur_frame % 8];
    end
  end

  initial begin
    #(TEST_CYCLES * 4 * 4 + 500);
    $display("watchdog: run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    script[0] = 64'hdeadbeff;
    script[1] = 64'h1111_2222_3333_4444;
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < BEATS * 4; j++) frames[i][j*32 +: 32] = $random(seed);
    end
    s_axi_aresetn = 1'b0;
    en = 1'b1;
    frame_valid = 1'b0;
    frame_data = frames[0];
    break_count = 64'd200;
    s_axi_bresp = 2'b00;
    s_axi_rresp = 2'b00;
    s_axi_rlast = 1'b1;
    s_axi_rdata = '0;
    s_axi_awready = 1'b0;
    s_axi_wready = 1'b0;
    s_axi_arready = 1'b0;
    s_axi_bvalid = 1'b0;
    s_axi_rvalid = 1'b0;

    // all strobes low in reset and one cycle after
    for (int c = 0; c < 4; c++) begin
      @(negedge s_axi_aclk);
      if (c == 2) s_axi_aresetn = 1'b1;
      check_val("strobes", 128'(0), 128'({s_axi_awvalid, s_axi_wvalid, s_axi_wlast,
                s_axi_bready, s_axi_arvalid, s_axi_rready, frame_ack}));
    end
    end_test();

    test_name = "writes";
    frame_valid = 1'b1;
    n = 0;
    while (bursts_done < FRAMES && n < 200) begin
      @(negedge s_axi_aclk);
      n++;
    end
    if (bursts_done < FRAMES) fail_wait("three bursts");
    end_test();

    test_name = "poll";
    n = 0;
    while ((releases < 1 || aw_count < FRAMES + 1) && n < 200) begin
      @(negedge s_axi_aclk);
      n++;
    end
    if (releases < 1 || aw_count < FRAMES + 1) fail_wait("doorbell release");
    // the unchanged first word costs one extra read
    check_val("reads before release", 128'(2), 128'(release_reads));
    end_test();

    test_name = "acks";
    n = 0;
    while (bursts_done < 2 * FRAMES && n < 200) begin
      @(negedge s_axi_aclk);
      n++;
    end
    if (bursts_done < 2 * FRAMES) fail_wait("second round");
    repeat (4) @(negedge s_axi_aclk);
    check_val("ack count", 128'(acks_expected), 128'(acks));
    check_val("acks in two rounds", 128'(5), 128'(acks));
    end_test();

    test_name = "counters";
    n = 0;
    while (all_cycle != 64'd200 && n < 300) begin
      @(negedge s_axi_aclk);
      n++;
    end
    if (all_cycle != 64'd200) fail_wait("all_cycle at break_count");
    repeat (4) begin
      @(negedge s_axi_aclk);
      check_val("all_cycle held", 128'(200), 128'(all_cycle));
    end
    check_val("cpu_cycle", 128'(exp_cpu), 128'(cpu_cycle));
    en = 1'b0;
    @(negedge s_axi_aclk);
    check_val("all_cycle cleared", 128'(0), 128'(all_cycle));
    check_val("cpu_cycle kept", 128'(exp_cpu), 128'(cpu_cycle));
    end_test();

    $display("summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/axi_bus_pkg.sv
hw/frame_pkg.sv
hw/frame_sequencer.sv
hw/frame_beat_path.sv
hw/frame_addr_gen.sv
hw/doorbell_tracker.sv
hw/cycle_counters.sv
hw/frame_writer_top.sv
test/frame_writer_sva.sv
test/tb_frame_writer.sv

/* Makefile */
TOP = tb_frame_writer

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
